/* src/ahb_bus_pkg.sv */
// AHB bus field widths for the shared slave port
// Transfer type enum in AHB HTRANS encoding
// Burst type enum in AHB HBURST encoding
`default_nettype none

package ahb_bus_pkg;

  // -------------------------------------------------------------------------
  // Field widths
  // -------------------------------------------------------------------------
  localparam int ADDR_W   = 32;               // HADDR
  localparam int DATA_W   = 32;               // HWDATA
  localparam int SIZE_W   = 3;                // HSIZE
  localparam int BURST_W  = 3;                // HBURST
  localparam int PROT_W   = 4;                // HPROT
  localparam int MASTER_W = 4;                // HMASTER

  // -------------------------------------------------------------------------
  // Transfer and burst codes
  // -------------------------------------------------------------------------
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,                    // No transfer
    HTRANS_BUSY   = 2'b01,                    // Pause inside a burst
    HTRANS_NONSEQ = 2'b10,                    // First or single beat
    HTRANS_SEQ    = 2'b11                     // Continuing beat
  } htrans_e;

  typedef enum logic [BURST_W-1:0] {
    HBURST_SINGLE = 3'b000,                   // Single transfer
    HBURST_INCR   = 3'b001,                   // Undefined length incr
    HBURST_WRAP4  = 3'b010,
    HBURST_INCR4  = 3'b011,
    HBURST_WRAP8  = 3'b100,
    HBURST_INCR8  = 3'b101,
    HBURST_WRAP16 = 3'b110,
    HBURST_INCR16 = 3'b111
  } hburst_e;

endpackage

`default_nettype wire

/* src/output_stage_pkg.sv */
// Output stage port count
// Port-select enum shared by arbiter, muxes and data phase
// Helper mapping a port choice to an array index
`default_nettype none

package output_stage_pkg;

  localparam int NUM_PORTS = 3;               // Bus-switch inputs

  // PORT_NONE marks an idle output stage
  typedef enum logic [1:0] {
    PORT_NONE = 2'd0,                         // No owner
    PORT_1    = 2'd1,
    PORT_2    = 2'd2,
    PORT_3    = 2'd3
  } port_sel_e;

  // Array index of a port, -1 for PORT_NONE
  function automatic int port_index(input port_sel_e port);
    return int'(port) - 1;
  endfunction

endpackage

`default_nettype wire

/* src/output_arbiter.sv */
// Round-robin arbiter for the shared slave
// Grant hold across SEQ/BUSY beats and locked sequences
// Lock tracking while the locking master addresses elsewhere
`timescale 1ns/1ps
`default_nettype none

module output_arbiter
  import output_stage_pkg::*;
  import ahb_bus_pkg::*;
(
  input  wire                  HCLK,          // AHB clock
  input  wire                  HRESETn,       // Sync reset, active low
  input  wire [NUM_PORTS-1:0]  i_req,         // Port requests, bit 0 is port 1
  input  wire                  i_hready,      // Muxed ready, advance strobe
  input  wire                  i_hsel,        // Muxed select of current owner
  input  wire htrans_e         i_htrans,      // Muxed transfer type
  input  wire                  i_hmastlock,   // Muxed lock of current owner
  output port_sel_e            o_addr_port    // Registered address-phase port
);

  // -------------------------------------------------------------------------
  // Lock tracking and hold decision
  // -------------------------------------------------------------------------
  logic      lock_flag;                       // Locked sequence in progress
  logic      next_lock;
  logic      lock_arb;                        // Effective lock for arbitration
  logic      burst_hold;                      // Owner still mid-burst
  logic      hold_grant;
  port_sel_e last_port;                       // Last port given a grant
  port_sel_e next_port;                       // Round-robin winner

  // Set on a selected locked transfer, clear once mastlock drops
  always_comb
  begin
    if (i_hsel && i_hmastlock &&
        (i_htrans == HTRANS_NONSEQ || i_htrans == HTRANS_SEQ))
      next_lock = 1'b1;
    else if (!i_hmastlock)
      next_lock = 1'b0;
    else
      next_lock = lock_flag;                  // Owner briefly elsewhere
  end

  assign lock_arb   = i_hmastlock & (lock_flag | i_hsel);
  assign burst_hold = i_hsel & (i_htrans == HTRANS_SEQ || i_htrans == HTRANS_BUSY);
  assign hold_grant = lock_arb | burst_hold;

  // -------------------------------------------------------------------------
  // Round-robin search starting after the last granted port
  // -------------------------------------------------------------------------
  always_comb
  begin
    int cand;
    next_port = PORT_NONE;                    // Nobody requesting
    // Walk backwards so the nearest requester wins
    for (int k = NUM_PORTS; k >= 1; k--)
    begin
      cand = (port_index(last_port) + k) % NUM_PORTS;
      if (i_req[cand])
        next_port = port_sel_e'(cand + 1);
    end
  end

  // -------------------------------------------------------------------------
  // Grant registers, advance only on accepted cycles
  // -------------------------------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      o_addr_port <= PORT_NONE;
      last_port   <= PORT_3;                  // Port 1 first after reset
      lock_flag   <= 1'b0;
    end
    else if (i_hready)
    begin
      lock_flag <= next_lock;
      if (!hold_grant)
      begin
        o_addr_port <= next_port;
        if (next_port != PORT_NONE)
          last_port <= next_port;             // Rotation point
      end
    end
  end

endmodule

`default_nettype wire

/* src/addr_phase_mux.sv */
// Address and control multiplexer onto the shared slave
// One-hot active decode of the granted port
`timescale 1ns/1ps
`default_nettype none

module addr_phase_mux
  import output_stage_pkg::*;
  import ahb_bus_pkg::*;
(
  input  wire port_sel_e             i_addr_port,            // Granted port
  input  wire                        i_sel      [NUM_PORTS], // Per-port HSEL
  input  wire [ADDR_W-1:0]           i_addr     [NUM_PORTS],
  input  wire htrans_e               i_trans    [NUM_PORTS],
  input  wire                        i_write    [NUM_PORTS],
  input  wire [SIZE_W-1:0]           i_size     [NUM_PORTS],
  input  wire hburst_e               i_burst    [NUM_PORTS],
  input  wire [PROT_W-1:0]           i_prot     [NUM_PORTS],
  input  wire [MASTER_W-1:0]         i_master   [NUM_PORTS],
  input  wire                        i_mastlock [NUM_PORTS],
  output logic [NUM_PORTS-1:0]       o_active,               // Owner flags
  output logic                       o_hsel,
  output logic [ADDR_W-1:0]          o_haddr,
  output htrans_e                    o_htrans,
  output logic                       o_hwrite,
  output logic [SIZE_W-1:0]          o_hsize,
  output hburst_e                    o_hburst,
  output logic [PROT_W-1:0]          o_hprot,
  output logic [MASTER_W-1:0]        o_hmaster,
  output logic                       o_hmastlock
);

  // -------------------------------------------------------------------------
  // Field routing
  // -------------------------------------------------------------------------
  always_comb
  begin
    int idx;
    idx         = port_index(i_addr_port);
    // Idle bus when no port owns the slave
    o_active    = '0;
    o_hsel      = 1'b0;
    o_haddr     = '0;
    o_htrans    = HTRANS_IDLE;
    o_hwrite    = 1'b0;
    o_hsize     = '0;
    o_hburst    = HBURST_SINGLE;
    o_hprot     = '0;
    o_hmaster   = '0;
    o_hmastlock = 1'b0;

    if (i_addr_port != PORT_NONE)
    begin
      o_active[idx] = 1'b1;                   // Tell input stage it owns slave
      o_hsel        = i_sel[idx];
      o_haddr       = i_addr[idx];
      o_htrans      = i_trans[idx];
      o_hwrite      = i_write[idx];
      o_hsize       = i_size[idx];
      o_hburst      = i_burst[idx];           // Passed through only
      o_hprot       = i_prot[idx];
      o_hmaster     = i_master[idx];
      o_hmastlock   = i_mastlock[idx];
    end
  end

endmodule

`default_nettype wire

/* src/data_phase_ctrl.sv */
// Data-phase port and slave-select registers
// HREADYMUX generation from the slave ready
// Write-data multiplexer steered by the data-phase port
`timescale 1ns/1ps
`default_nettype none

module data_phase_ctrl
  import output_stage_pkg::*;
  import ahb_bus_pkg::*;
(
  input  wire                 HCLK,                 // AHB clock
  input  wire                 HRESETn,              // Sync reset, active low
  input  wire port_sel_e      i_addr_port,          // Address-phase port
  input  wire                 i_hsel,               // Address-phase select
  input  wire                 i_hreadyout,          // Slave ready
  input  wire [DATA_W-1:0]    i_wdata [NUM_PORTS],  // Per-port write data
  output logic                o_hreadymux,          // Transfer done
  output logic [DATA_W-1:0]   o_hwdata              // Slave write data
);

  port_sel_e data_port;                       // Port owning the data phase
  logic      slave_sel;                       // Slave addressed last phase

  // -------------------------------------------------------------------------
  // Address to data phase pipeline
  // -------------------------------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_port <= PORT_NONE;
      slave_sel <= 1'b0;
    end
    else if (o_hreadymux)                     // Accepted cycle only
    begin
      data_port <= i_addr_port;
      slave_sel <= i_hsel;
    end
  end

  // Slave drives ready only when it was addressed
  assign o_hreadymux = slave_sel ? i_hreadyout : 1'b1;

  // -------------------------------------------------------------------------
  // Write data steering
  // -------------------------------------------------------------------------
  always_comb
  begin
    o_hwdata = '0;                            // Quiet bus without owner
    if (data_port != PORT_NONE)
      o_hwdata = i_wdata[port_index(data_port)];
  end

endmodule

`default_nettype wire

/* src/ahb_output_stage.sv */
// Output stage of an AHB bus matrix for one shared slave
// Request forming from held transfers and selects
// Arbiter, address mux and data-phase control with feedback nets
`timescale 1ns/1ps
`default_nettype none

module ahb_output_stage
  import output_stage_pkg::*;
  import ahb_bus_pkg::*;
(
  input  wire                 HCLK,                    // AHB clock
  input  wire                 HRESETn,                 // Sync reset, active low
  // Bus-switch inputs, index 0 is port 1
  input  wire                 i_sel       [NUM_PORTS],
  input  wire [ADDR_W-1:0]    i_addr      [NUM_PORTS],
  input  wire htrans_e        i_trans     [NUM_PORTS],
  input  wire                 i_write     [NUM_PORTS],
  input  wire [SIZE_W-1:0]    i_size      [NUM_PORTS],
  input  wire hburst_e        i_burst     [NUM_PORTS],
  input  wire [PROT_W-1:0]    i_prot      [NUM_PORTS],
  input  wire [MASTER_W-1:0]  i_master    [NUM_PORTS],
  input  wire                 i_mastlock  [NUM_PORTS],
  input  wire [DATA_W-1:0]    i_wdata     [NUM_PORTS],
  input  wire                 i_held_tran [NUM_PORTS], // Input stage has a transfer
  input  wire                 i_hreadyout,             // Slave ready
  output logic [NUM_PORTS-1:0] o_active,               // Per-port ownership
  // Shared slave side
  output logic                o_hsel,
  output logic [ADDR_W-1:0]   o_haddr,
  output htrans_e             o_htrans,
  output logic                o_hwrite,
  output logic [SIZE_W-1:0]   o_hsize,
  output hburst_e             o_hburst,
  output logic [PROT_W-1:0]   o_hprot,
  output logic [MASTER_W-1:0] o_hmaster,
  output logic                o_hmastlock,
  output logic [DATA_W-1:0]   o_hwdata,
  output logic                o_hreadymux              // HREADYMUX
);

  // -------------------------------------------------------------------------
  // Internal nets
  // -------------------------------------------------------------------------
  logic [NUM_PORTS-1:0] req;                  // Arbitration requests
  port_sel_e            addr_port;            // Granted port
  logic                 hready_mux;           // Advance strobe
  logic                 mux_hsel;             // Muxed fields back to arbiter
  htrans_e              mux_htrans;
  logic                 mux_hmastlock;

  always_comb
  begin
    for (int p = 0; p < NUM_PORTS; p++)
      req[p] = i_held_tran[p] & i_sel[p];     // Held transfer aimed here
  end

  output_arbiter u_arbiter (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_req       (req),
    .i_hready    (hready_mux),
    .i_hsel      (mux_hsel),
    .i_htrans    (mux_htrans),
    .i_hmastlock (mux_hmastlock),
    .o_addr_port (addr_port)
  );

  addr_phase_mux u_addr_mux (
    .i_addr_port (addr_port),
    .i_sel       (i_sel),
    .i_addr      (i_addr),
    .i_trans     (i_trans),
    .i_write     (i_write),
    .i_size      (i_size),
    .i_burst     (i_burst),
    .i_prot      (i_prot),
    .i_master    (i_master),
    .i_mastlock  (i_mastlock),
    .o_active    (o_active),
    .o_hsel      (mux_hsel),
    .o_haddr     (o_haddr),
    .o_htrans    (mux_htrans),
    .o_hwrite    (o_hwrite),
    .o_hsize     (o_hsize),
    .o_hburst    (o_hburst),
    .o_hprot     (o_hprot),
    .o_hmaster   (o_hmaster),
    .o_hmastlock (mux_hmastlock)
  );

  data_phase_ctrl u_data_ctrl (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_addr_port (addr_port),
    .i_hsel      (mux_hsel),
    .i_hreadyout (i_hreadyout),
    .i_wdata     (i_wdata),
    .o_hreadymux (hready_mux),
    .o_hwdata    (o_hwdata)
  );

  // Feedback nets also drive the slave
  assign o_hsel      = mux_hsel;
  assign o_htrans    = mux_htrans;
  assign o_hmastlock = mux_hmastlock;
  assign o_hreadymux = hready_mux;

endmodule

`default_nettype wire

/* verification/tb_ahb_output_stage.sv */
// Testbench for the AHB output stage
// Reads per-cycle vectors, drives the three input ports on the falling edge
// Checks slave-side fields, active flags, ready mux and write-data steering
`timescale 1ns/1ps
`default_nettype none

module tb_ahb_output_stage
  import output_stage_pkg::*;
  import ahb_bus_pkg::*;
();

  localparam int    CLK_PERIOD    = 40;
  localparam int    RESET_CYCLES  = 5;
  localparam int    RESET_TIMEOUT = 20;       // Cycles allowed for reset release
  localparam int    MAX_LINES     = 200;      // Guard against a runaway file
  localparam int    SEED          = 4566;
  localparam string VEC_FILE      = "verification/output_stage_tests.txt";

  logic                 HCLK;
  logic                 HRESETn;
  logic                 i_sel       [NUM_PORTS];
  logic [ADDR_W-1:0]    i_addr      [NUM_PORTS];
  htrans_e              i_trans     [NUM_PORTS];
  logic                 i_write     [NUM_PORTS];
  logic [SIZE_W-1:0]    i_size      [NUM_PORTS];
  hburst_e              i_burst     [NUM_PORTS];
  logic [PROT_W-1:0]    i_prot      [NUM_PORTS];
  logic [MASTER_W-1:0]  i_master    [NUM_PORTS];
  logic                 i_mastlock  [NUM_PORTS];
  logic [DATA_W-1:0]    i_wdata     [NUM_PORTS];
  logic                 i_held_tran [NUM_PORTS];
  logic                 i_hreadyout;
  logic [NUM_PORTS-1:0] o_active;
  logic                 o_hsel;
  logic [ADDR_W-1:0]    o_haddr;
  htrans_e              o_htrans;
  logic                 o_hwrite;
  logic [SIZE_W-1:0]    o_hsize;
  hburst_e              o_hburst;
  logic [PROT_W-1:0]    o_hprot;
  logic [MASTER_W-1:0]  o_hmaster;
  logic                 o_hmastlock;
  logic [DATA_W-1:0]    o_hwdata;
  logic                 o_hreadymux;

  // Data-phase reference state with port 0 as none
  logic model_sel;                            // Slave addressed in last accepted phase
  int   model_addr_port;                      // Grant shown on the previous line
  int   model_data_port;                      // Port owning the data phase

  ahb_output_stage DUT (.*);

  // --------------------------------------------------------------------------
  // Clock and reset
  // --------------------------------------------------------------------------
  initial
  begin
    HCLK = 1'b0;
    forever #(CLK_PERIOD/2) HCLK = ~HCLK;
  end

  initial
  begin
    HRESETn = 1'b0;
    repeat (RESET_CYCLES) @(negedge HCLK);
    HRESETn = 1'b1;                           // Released on a falling edge
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string test, input string field,
                             input logic [31:0] exp_val, input logic [31:0] act_val);
    if (exp_val !== act_val)
      abort_run($sformatf("Mismatch %s %s: expected 0x%0h, actual 0x%0h",
                          test, field, exp_val, act_val));
  endtask

  task automatic init_inputs();
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      i_sel[p]       = 1'b0;
      i_addr[p]      = '0;
      i_trans[p]     = HTRANS_IDLE;
      i_write[p]     = 1'(p % 2);             // Control fields differ per port
      i_size[p]      = SIZE_W'(p);
      i_burst[p]     = hburst_e'(BURST_W'(p + 2));
      i_prot[p]      = PROT_W'(p + 5);
      i_master[p]    = MASTER_W'(p + 1);      // Master id equals port number
      i_mastlock[p]  = 1'b0;
      i_wdata[p]     = '0;
      i_held_tran[p] = 1'b0;
    end
    i_hreadyout     = 1'b1;
    model_sel       = 1'b0;
    model_addr_port = 0;
    model_data_port = 0;
  endtask

  // Trans nibble p holds the code of port p+1
  task automatic drive_ports(input logic [NUM_PORTS-1:0] req, input logic [NUM_PORTS-1:0] sel,
                             input logic [NUM_PORTS-1:0] lock, input logic [11:0] trans,
                             input logic rdy);
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      i_held_tran[p] = req[p];
      i_sel[p]       = sel[p];
      i_mastlock[p]  = lock[p];
      i_trans[p]     = htrans_e'(trans[4*p +: 2]);
      i_addr[p]      = $urandom;              // Wildcard fields
      i_wdata[p]     = $urandom;
    end
    i_hreadyout = rdy;
  endtask

  // Advance the data-phase reference after the rising edge of a line
  task automatic track_data_phase(input logic rdy, input int exp_port);
    logic accepted;
    accepted = model_sel ? rdy : 1'b1;        // Slave ready counts only if addressed
    if (accepted)
    begin
      model_data_port = model_addr_port;
      model_sel       = 1'b0;
      if (model_addr_port != 0)
        model_sel = i_sel[model_addr_port-1];
    end
    model_addr_port = exp_port;
  endtask

  task automatic check_outputs(input string test, input logic [NUM_PORTS-1:0] exp_act,
                               input int exp_port, input logic exp_rdy);
    logic [31:0] e_sel;
    logic [31:0] e_addr;
    logic [31:0] e_trans;
    logic [31:0] e_write;
    logic [31:0] e_size;
    logic [31:0] e_burst;
    logic [31:0] e_prot;
    logic [31:0] e_lock;
    logic [31:0] e_master;
    logic [31:0] e_wdata;
    e_sel    = '0;                            // Idle slave bus by default
    e_addr   = '0;
    e_trans  = 32'(HTRANS_IDLE);
    e_write  = '0;
    e_size   = '0;
    e_burst  = 32'(HBURST_SINGLE);
    e_prot   = '0;
    e_lock   = '0;
    e_master = '0;
    e_wdata  = '0;
    if (exp_port != 0)
    begin
      e_sel    = 32'(i_sel[exp_port-1]);
      e_addr   = i_addr[exp_port-1];
      e_trans  = 32'(i_trans[exp_port-1]);
      e_write  = 32'(i_write[exp_port-1]);
      e_size   = 32'(i_size[exp_port-1]);
      e_burst  = 32'(i_burst[exp_port-1]);
      e_prot   = 32'(i_prot[exp_port-1]);
      e_lock   = 32'(i_mastlock[exp_port-1]);
      e_master = exp_port;
    end
    if (model_data_port != 0)
      e_wdata = i_wdata[model_data_port-1];
    check_value(test, "o_active", 32'(exp_act), 32'(o_active));
    check_value(test, "o_hsel", e_sel, 32'(o_hsel));
    check_value(test, "o_haddr", e_addr, o_haddr);
    check_value(test, "o_htrans", e_trans, 32'(o_htrans));
    check_value(test, "o_hwrite", e_write, 32'(o_hwrite));
    check_value(test, "o_hsize", e_size, 32'(o_hsize));
    check_value(test, "o_hburst", e_burst, 32'(o_hburst));
    check_value(test, "o_hprot", e_prot, 32'(o_hprot));
    check_value(test, "o_hmastlock", e_lock, 32'(o_hmastlock));
    check_value(test, "o_hmaster", e_master, 32'(o_hmaster));
    check_value(test, "o_hreadymux", 32'(exp_rdy), 32'(o_hreadymux));
    check_value(test, "o_hwdata", e_wdata, o_hwdata);
  endtask

  // --------------------------------------------------------------------------
  // Vector loop
  // --------------------------------------------------------------------------
  initial
  begin
    int                   fd;
    int                   code;
    int                   lines_read;
    int                   vectors;
    int                   wait_cycles;
    int                   exp_port;
    bit                   done;
    string                line;
    string                test_name;
    logic [NUM_PORTS-1:0] req;
    logic [NUM_PORTS-1:0] sel;
    logic [NUM_PORTS-1:0] lock;
    logic [NUM_PORTS-1:0] exp_act;
    logic [11:0]          trans;
    logic                 rdy;
    logic                 exp_rdy;
    void'($urandom(SEED));
    init_inputs();

    wait_cycles = 0;
    while (HRESETn !== 1'b1 && wait_cycles < RESET_TIMEOUT)
    begin
      @(posedge HCLK);
      wait_cycles++;
    end
    if (HRESETn !== 1'b1)
      abort_run("Reset was not released within the timeout");

    fd = $fopen(VEC_FILE, "r");
    if (fd == 0)
      abort_run("Could not open the vector file");

    lines_read = 0;
    vectors    = 0;
    done       = 1'b0;
    while (!done && lines_read < MAX_LINES)
    begin
      code = $fgets(line, fd);
      if (code == 0)
        done = 1'b1;                          // End of file
      else
      begin
        lines_read++;
        if (line.len() > 1 && line[0] != "#")
        begin
          code = $sscanf(line, "%s %b %b %b %h %b %b %d %b", test_name, req, sel, lock,
                         trans, rdy, exp_act, exp_port, exp_rdy);
          if (code != 9)
            abort_run($sformatf("Vector line %0d could not be parsed", lines_read));
          @(negedge HCLK);
          drive_ports(req, sel, lock, trans, rdy);
          @(posedge HCLK);
          #(CLK_PERIOD/2 - 1);                // Just before the next falling edge
          track_data_phase(rdy, exp_port);
          check_outputs(test_name, exp_act, exp_port, exp_rdy);
          vectors++;
        end
      end
    end
    $fclose(fd);

    if (!done)
      abort_run("Vector file is longer than the line limit");
    if (vectors == 0)
      abort_run("Vector file holds no test vectors");
    else
    begin
      $display("%0d vectors checked", vectors);
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* ahb_output_stage.f */
src/ahb_bus_pkg.sv
src/output_stage_pkg.sv
src/output_arbiter.sv
src/addr_phase_mux.sv
src/data_phase_ctrl.sv
src/ahb_output_stage.sv
verification/tb_ahb_output_stage.sv

/* verification/output_stage_tests.txt */
# test req sel lock trans hreadyout | exp_active exp_port exp_hreadymux
# Bit fields and trans digits list port 3 first; trans 0 IDLE 1 BUSY 2 NONSEQ 3 SEQ
reset_idle   000 000 000 000 1  000 0 1
reset_idle   000 000 000 000 1  000 0 1
round_robin  111 111 000 222 1  001 1 1
round_robin  111 111 000 222 1  010 2 1
round_robin  111 111 000 222 1  100 3 1
round_robin  111 111 000 222 1  001 1 1
round_robin  111 111 000 222 1  010 2 1
seq_hold     111 111 000 222 1  100 3 1
seq_hold     111 111 000 322 1  100 3 1
seq_hold     111 111 000 122 1  100 3 1
seq_hold     111 111 000 322 1  100 3 1
seq_hold     011 111 000 022 1  001 1 1
seq_hold     011 111 000 022 1  010 2 1
lock_hold    001 001 001 002 1  001 1 1
lock_hold    111 111 001 222 1  001 1 1
lock_hold    110 110 001 222 1  001 1 1
lock_hold    111 111 001 223 1  001 1 1
lock_hold    110 111 000 220 1  010 2 1
wait_states  010 010 000 020 1  010 2 1
wait_states  101 111 000 222 0  010 2 0
wait_states  101 111 000 222 0  010 2 0
wait_states  101 111 000 222 1  100 3 1
wait_states  000 000 000 000 1  000 0 1
wait_states  000 000 000 000 1  000 0 1
single_p2    010 010 000 020 1  010 2 1
single_p2    000 010 000 020 1  000 0 1
single_p2    000 000 000 000 1  000 0 1
